// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_flim_hist
FILELIST := sim.f
MDIR     := obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(MDIR)

run: $(BIN) tb/flim_hist_trace.txt
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "^All tests passed$$"

clean:
	rm -rf $(MDIR)

// ==== hw/bin_quantizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bin_quantizer import flim_pkg::*; #(
    parameter int bin_shift = 4
) (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   tdc_valid,
    input  code_t  tdc_code,
    output logic   hit_valid,
    output bin_t   hit_bin
);

    // coarse time, code divided by the bin width
    code_t quotient;
    logic in_range;

    assign quotient = tdc_code >> bin_shift;

    // anything past the last bin is dropped
    assign in_range = (quotient < code_t'(n_bins));

    // strobe only for accepted codes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= tdc_valid && in_range;
        end
    end

    // bin index rides with the strobe
    always_ff @(posedge clk) begin
        if (tdc_valid && in_range) begin
            hit_bin <= quotient[bin_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/flim_hist_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module flim_hist_top import flim_pkg::*; #(
    parameter int hits_per_pixel = 2,
    parameter int acq_num = 2,
    parameter int bin_shift = 4
) (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   tdc_valid,
    input  code_t  tdc_code,
    output logic   out_valid,
    output pixel_t out_pixel,
    output bin_t   out_bin,
    output count_t out_count,
    output logic   out_last,
    output logic   frame_done,
    output logic   overrun
);

    // quantized hit strobe
    logic hit_valid;
    bin_t hit_bin;

    // read and release port of the completed bank
    hist_rd_if u_rd_if ();

    bin_quantizer #(
        .bin_shift (bin_shift)
    ) u_bin_quantizer (
        .clk        (clk),
        .combin_res (combin_res),
        .tdc_valid  (tdc_valid),
        .tdc_code   (tdc_code),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin)
    );

    hist_builder #(
        .hits_per_pixel (hits_per_pixel),
        .acq_num        (acq_num)
    ) u_hist_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .frame_done (frame_done),
        .overrun    (overrun),
        .rd         (u_rd_if.builder)
    );

    // starts on the frame pulse
    hist_readout u_hist_readout (
        .clk        (clk),
        .combin_res (combin_res),
        .frame_done (frame_done),
        .rd         (u_rd_if.readout),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_last   (out_last)
    );

endmodule

`default_nettype wire

// ==== hw/flim_pkg.sv ====
`default_nettype none

package flim_pkg;

    // pixel array index width, four pixels
    localparam int pixel_w = 2;

    // time bin index width, eight bins
    localparam int bin_w = 3;

    // raw tdc timestamp width
    localparam int code_w = 8;

    // histogram count width, saturating
    localparam int count_w = 8;

    // array sizes
    localparam int n_pixels = 1 << pixel_w;
    localparam int n_bins = 1 << bin_w;

    // one histogram bank holds every pixel's bins
    localparam int addr_w = pixel_w + bin_w;
    localparam int n_entries = n_pixels * n_bins;

    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [bin_w-1:0] bin_t;
    typedef logic [code_w-1:0] code_t;
    typedef logic [count_w-1:0] count_t;

    // pixel in the upper bits, so the flat index is pixel major
    typedef struct packed {
        pixel_t pixel;
        bin_t bin;
    } hist_idx_t;

    // flat view indexes memory, idx view builds the address
    typedef union packed {
        logic [addr_w-1:0] flat;
        hist_idx_t idx;
    } hist_addr_u;

endpackage

`default_nettype wire

// ==== hw/hist_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_builder import flim_pkg::*; #(
    parameter int hits_per_pixel = 2,
    parameter int acq_num = 2
) (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   hit_valid,
    input  bin_t   hit_bin,
    output logic   frame_done,
    output logic   overrun,
    hist_rd_if.builder rd
);

    // counter widths, at least one bit each
    localparam int hit_cw = (hits_per_pixel > 1) ? $clog2(hits_per_pixel) : 1;
    localparam int acq_cw = (acq_num > 1) ? $clog2(acq_num) : 1;

    // two banks, one fills while the other drains
    count_t hist_mem [2][n_entries];

    // first-write bits per bank, entry invalid reads as zero
    logic [n_entries-1:0] valid_map [2];

    // sequencing counters
    logic [hit_cw-1:0] hit_cnt;
    pixel_t pixel_cnt;
    logic [acq_cw-1:0] acq_cnt;

    // bank being filled, the other one is read
    logic active_bank;
    logic rd_bank;

    logic hit_last;
    logic pixel_last;
    logic acq_last;
    logic frame_end;

    hist_addr_u wr_addr;
    count_t cur_count;
    logic cur_valid;

    assign rd_bank = ~active_bank;

    // address of the current hit
    always_comb begin
        wr_addr.idx.pixel = pixel_cnt;
        wr_addr.idx.bin = hit_bin;
    end

    assign cur_count = hist_mem[active_bank][wr_addr.flat];
    assign cur_valid = valid_map[active_bank][wr_addr.flat];

    // wrap points of the nested counters
    assign hit_last = (hit_cnt == hit_cw'(hits_per_pixel - 1));
    assign pixel_last = (pixel_cnt == pixel_t'(n_pixels - 1));
    assign acq_last = (acq_cnt == acq_cw'(acq_num - 1));

    // last hit of the last pixel group of the last acquisition
    assign frame_end = hit_valid && hit_last && pixel_last && acq_last;

    // count update, first write loads one
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            if (!cur_valid) begin
                hist_mem[active_bank][wr_addr.flat] <= count_t'(1);
            end else if (cur_count != '1) begin
                hist_mem[active_bank][wr_addr.flat] <= cur_count + 1'b1;
            end
        end
    end

    // mark on write, wipe the bank that becomes active
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid_map[0] <= '0;
            valid_map[1] <= '0;
        end else begin
            if (hit_valid) begin
                valid_map[active_bank][wr_addr.flat] <= 1'b1;
            end
            if (frame_end) begin
                valid_map[rd_bank] <= '0;
            end
        end
    end

    // hit, pixel and acquisition sequencing
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt <= '0;
        end else if (hit_valid) begin
            if (!hit_last) begin
                hit_cnt <= hit_cnt + 1'b1;
            end else begin
                hit_cnt <= '0;
                // pixel count wraps on its own, array is a power of two
                pixel_cnt <= pixel_cnt + 1'b1;
                if (pixel_last) begin
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // bank swap, frame pulse and readout ownership
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            active_bank <= 1'b0;
            frame_done <= 1'b0;
            overrun <= 1'b0;
            rd.busy <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (frame_end) begin
                active_bank <= ~active_bank;
            end
            // previous bank still streaming, sticky
            if (frame_end && rd.busy && !rd.release_bank) begin
                overrun <= 1'b1;
            end
            if (frame_end) begin
                rd.busy <= 1'b1;
            end else if (rd.release_bank) begin
                rd.busy <= 1'b0;
            end
        end
    end

    // read side sees the completed bank only
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            if (valid_map[rd_bank][rd.rd_addr.flat]) begin
                rd.rd_count <= hist_mem[rd_bank][rd.rd_addr.flat];
            end else begin
                rd.rd_count <= '0;
            end
        end
    end

    // readout must only touch a bank it owns
    a_read_while_busy: assert property (
        @(posedge clk) disable iff (!combin_res) rd.rd_en |-> rd.busy
    ) else $error("histogram read outside a busy window");

    a_release_while_busy: assert property (
        @(posedge clk) disable iff (!combin_res) rd.release_bank |-> rd.busy
    ) else $error("bank release outside a busy window");

endmodule

`default_nettype wire

// ==== hw/hist_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hist_rd_if import flim_pkg::*; ();

    // read strobe and address from the readout
    logic rd_en;
    hist_addr_u rd_addr;

    // pulse when the whole bank has been streamed
    logic release_bank;

    // registered read data, one cycle after rd_en
    count_t rd_count;

    // completed bank owned by the readout
    logic busy;

    modport builder (
        input  rd_en,
        input  rd_addr,
        input  release_bank,
        output rd_count,
        output busy
    );

    modport readout (
        output rd_en,
        output rd_addr,
        output release_bank,
        input  rd_count,
        input  busy
    );

endinterface

`default_nettype wire

// ==== hw/hist_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_readout import flim_pkg::*; (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   frame_done,
    hist_rd_if.readout rd,
    output logic   out_valid,
    output pixel_t out_pixel,
    output bin_t   out_bin,
    output count_t out_count,
    output logic   out_last
);

    // readout states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_reading = 2'd1;
    localparam logic [1:0] st_release = 2'd2;

    logic [1:0] state;

    // walks the bank in flat order, pixel major
    hist_addr_u rd_ptr;

    // address of the word now on rd_count
    hist_addr_u addr_q;

    logic ptr_last;

    assign ptr_last = (rd_ptr.flat == addr_w'(n_entries - 1));

    // one read per cycle while reading
    assign rd.rd_en = (state == st_reading);
    assign rd.rd_addr = rd_ptr;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= st_idle;
            rd_ptr <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
            rd.release_bank <= 1'b0;
        end else begin
            // output flags line up with the registered count
            out_valid <= rd.rd_en;
            out_last <= rd.rd_en && ptr_last;
            // hand the bank back right after the last word
            rd.release_bank <= out_last;
            case (state)
                st_idle: begin
                    if (frame_done) begin
                        state <= st_reading;
                        rd_ptr <= '0;
                    end
                end
                st_reading: begin
                    rd_ptr.flat <= rd_ptr.flat + 1'b1;
                    if (ptr_last) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    // wait out the final word and the release pulse
                    if (rd.release_bank) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // delayed address so indices match the count
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            addr_q <= rd_ptr;
        end
    end

    assign out_pixel = addr_q.idx.pixel;
    assign out_bin = addr_q.idx.bin;
    assign out_count = rd.rd_count;

    // builder must not finish a frame mid-stream
    a_no_frame_while_reading: assert property (
        @(posedge clk) disable iff (!combin_res) frame_done |-> (state != st_reading)
    ) else $error("frame done while readout is streaming");

endmodule

`default_nettype wire

// ==== sim.f ====
hw/flim_pkg.sv
hw/hist_rd_if.sv
hw/bin_quantizer.sv
hw/hist_builder.sv
hw/hist_readout.sv
hw/flim_hist_top.sv
tb/tb_flim_hist.sv

// ==== tb/flim_hist_trace.txt ====
# H tdc_code(hex) | I idle_cycles | E pixel bin expected_count
# F closes the expectations of one frame, E lines follow all H and I lines
H 05
H 12
H 80
H 23
H 2f
H 7f
H 70
H ff
H 44
H 3a
H 09
H 11
H 2a
H 55
H 9c
H 7e
H 61
H 48
H 4c
H 31
H 33
H 60
H 6f
I 10
H 02
H 0e
H 57
H 5a
I 10
H 3c
H 38
H 66
H 61
I 10
H 0f
H 00
H 50
H 5f
E 0 0 2
E 0 1 2
E 1 2 3
E 1 5 1
E 2 7 3
E 2 6 1
E 3 4 3
E 3 3 1
F
E 0 3 4
E 1 6 4
E 2 0 4
E 3 5 4
F

// ==== tb/tb_flim_hist.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_flim_hist import flim_pkg::*; ();

    logic clk;
    logic combin_res;
    logic tdc_valid;
    code_t tdc_code;
    logic out_valid;
    pixel_t out_pixel;
    bin_t out_bin;
    count_t out_count;
    logic out_last;
    logic frame_done;
    logic overrun;

    // stimulus ops from the trace, hit code or idle cycles
    bit op_is_hit [$];
    int op_arg [$];

    // expected bank contents per frame, unlisted entries stay zero
    count_t exp_count [2][n_entries];
    int n_frames;

    flim_hist_top u_flim_hist_top (
        .clk        (clk),
        .combin_res (combin_res),
        .tdc_valid  (tdc_valid),
        .tdc_code   (tdc_code),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_last   (out_last),
        .frame_done (frame_done),
        .overrun    (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(string what);
        $display("%s at %0t ns", what, $time);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_count(count_t got, count_t exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_index(pixel_t got_p, bin_t got_b, pixel_t exp_p, bin_t exp_b);
        if (got_p !== exp_p || got_b !== exp_b) begin
            $display("FAIL at %0t ns: word at pixel %0d bin %0d, expected pixel %0d bin %0d",
                     $time, got_p, got_b, exp_p, exp_b);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // H code, I cycles, E pixel bin count, F closes a frame
    task automatic load_trace();
        int fd;
        int rc;
        int a;
        int b;
        int c;
        string text;
        foreach (exp_count[f, e]) exp_count[f][e] = '0;
        n_frames = 0;
        fd = $fopen("tb/flim_hist_trace.txt", "r");
        if (fd == 0) stop_run("trace file tb/flim_hist_trace.txt could not be opened");
        while (!$feof(fd)) begin
            text = "";
            rc = $fgets(text, fd);
            if (text.len() > 1 && text.getc(0) != "#") begin
                case (text.getc(0))
                    "H": begin
                        rc = $sscanf(text, "H %h", a);
                        op_is_hit.push_back(1'b1);
                        op_arg.push_back(a);
                    end
                    "I": begin
                        rc = $sscanf(text, "I %d", a);
                        op_is_hit.push_back(1'b0);
                        op_arg.push_back(a);
                    end
                    "E": begin
                        rc = $sscanf(text, "E %d %d %d", a, b, c);
                        if (rc != 3 || n_frames > 1) stop_run("bad expectation line in trace");
                        exp_count[n_frames][a * n_bins + b] = count_t'(c);
                    end
                    "F": n_frames++;
                    default: stop_run("unknown line kind in trace");
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_hit(code_t code);
        @(posedge clk);
        #10;
        tdc_valid = 1'b1;
        tdc_code = code;
    endtask

    task automatic drive_idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #10;
            tdc_valid = 1'b0;
        end
    endtask

    // mid cycle, well clear of both edges
    task automatic next_sample();
        @(posedge clk);
        #50;
    endtask

    initial begin : stimulus
        int i;
        combin_res = 1'b0;
        tdc_valid = 1'b0;
        tdc_code = '0;
        load_trace();
        repeat (16) @(posedge clk);
        #10;
        // reset state of the output flags
        check_flag(out_valid, 1'b0, "out_valid in reset");
        check_flag(frame_done, 1'b0, "frame_done in reset");
        check_flag(overrun, 1'b0, "overrun in reset");
        combin_res = 1'b1;
        for (i = 0; i < op_is_hit.size(); i++) begin
            if (op_is_hit[i]) begin
                drive_hit(code_t'(op_arg[i]));
            end else begin
                drive_idle(op_arg[i]);
            end
        end
        drive_idle(1);
    end

    initial begin : monitor
        int frame;
        int waited;
        int k;
        next_sample();
        for (frame = 0; frame < n_frames; frame++) begin
            // no stray words before the frame closes
            waited = 0;
            do begin
                next_sample();
                check_flag(out_valid, 1'b0, "out_valid before frame_done");
                waited++;
                if (waited > 200) stop_run("timed out waiting for frame_done");
            end while (!frame_done);
            waited = 0;
            do begin
                next_sample();
                // frame pulse lasts a single cycle
                check_flag(frame_done, 1'b0, "frame_done after its pulse");
                waited++;
                if (waited > 8) stop_run("timed out waiting for the first readout word");
            end while (!out_valid);
            check_flag(waited == 2, 1'b1, "first word two cycles after frame_done");
            // whole bank, pixel major, back to back
            for (k = 0; k < n_entries; k++) begin
                if (k > 0) next_sample();
                check_flag(out_valid, 1'b1, "out_valid inside the stream");
                check_index(out_pixel, out_bin, pixel_t'(k / n_bins), bin_t'(k % n_bins));
                check_count(out_count, exp_count[frame][k], "histogram");
                check_flag(out_last, k == n_entries - 1, "out_last");
                check_flag(overrun, 1'b0, "overrun");
            end
            next_sample();
            check_flag(out_valid, 1'b0, "out_valid after the last word");
        end
        check_flag(overrun, 1'b0, "overrun at end of run");
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
